// File: verilog.f
common/pcs_pkg.sv
clock_comp/sync_fifo.sv
src/lane_distributor.sv
lane_am/lane_am_checker.sv
src/lane_merger.sv
clock_comp/clock_comp_rx.sv
src/rx_block_fsm.sv
src/pcs_rx_backend.sv
dv/tb_pcs_rx_backend.sv

// File: Bender.yml
package:
  name: pcs_rx_backend

sources:
  - common/pcs_pkg.sv
  - clock_comp/sync_fifo.sv
  - src/lane_distributor.sv
  - lane_am/lane_am_checker.sv
  - src/lane_merger.sv
  - clock_comp/clock_comp_rx.sv
  - src/rx_block_fsm.sv
  - src/pcs_rx_backend.sv
  - target: simulation
    files:
      - dv/tb_pcs_rx_backend.sv

// File: dv/tb_pcs_rx_backend.sv
`timescale 1ns/1ps

module tb_pcs_rx_backend
        import pcs_pkg::*;
();

        localparam int N_LANES         = 4;
        localparam int AM_BLOCK_PERIOD = 16;
        localparam int PERIOD          = N_LANES * AM_BLOCK_PERIOD;    // Blocks per marker period
        localparam int RESET_CYCLES    = 16;
        localparam int LATENCY         = 5;     // Distributor, checker, merger, two in clock comp
        localparam int N_PERIODS       = 7;
        localparam int CORRUPT_PERIOD  = 3;     // All lanes locked by then
        localparam int CORRUPT_LANE    = 2;
        localparam logic [63:0] CORRUPT_MASK = 64'h0000_0100_0000_0000;
        // At most one gap cycle per block, so two cycles per block worst case
        localparam int CYCLE_LIMIT = RESET_CYCLES + 2 * N_PERIODS * PERIOD + 4 * LATENCY + 32;

        localparam int S_HUNT = 0;
        localparam int S_ONE  = 1;
        localparam int S_LOCK = 2;

        typedef struct packed {
                pcs_block_t         blk;        // Expected output block
                logic [N_LANES-1:0] lock;       // Lock vector after this block
                logic               lock_chk;   // Lock settled at this slot
                logic               period_end;
                logic [31:0]        idles_in;   // Input idles so far
                logic [31:0]        removed;    // Markers removed so far
        } expect_t;

        logic               i_clock = 1'b0;
        logic               i_rst_n;
        logic               i_valid;
        pcs_block_t         i_block;
        logic               o_valid;
        pcs_block_t         o_block;
        logic [N_LANES-1:0] o_lane_locked;

        logic [31:0]          lcg_state = 32'd12;
        int                   ref_state [N_LANES] = '{default: S_HUNT};      // Model lock FSMs
        expect_t              exp_q [$];
        logic [LATENCY-1:0]   valid_hist = '0;
        int                   cycle_cnt = 0;
        int                   in_valid_cnt = 0;
        int                   in_idles = 0;
        int                   removed_cnt = 0;
        int                   markers_passed = 0;
        int                   out_valid_cnt = 0;
        int                   out_idles = 0;
        int                   markers_seen = 0;

        always #2 i_clock = ~i_clock;           // 4 ns period

        pcs_rx_backend #(
                .N_LANES         (N_LANES),
                .AM_BLOCK_PERIOD (AM_BLOCK_PERIOD)
        ) pcs_rx_backend_inst (
                .i_clock       (i_clock),
                .i_rst_n       (i_rst_n),
                .i_valid       (i_valid),
                .i_block       (i_block),
                .o_valid       (o_valid),
                .o_block       (o_block),
                .o_lane_locked (o_lane_locked)
        );

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state ^ (lcg_state >> 16);   // Fold high bits down
        endfunction

        function automatic pcs_block_t random_data();
                pcs_block_t blk;
                blk.sh      = SH_DATA;
                blk.payload = {lcg_next(), lcg_next()};
                return blk;
        endfunction

        function automatic logic is_marker(input pcs_block_t blk);
                logic hit;
                hit = 1'b0;
                for (int l = 0; l < N_LANES; l++)
                        if (blk.sh == SH_CTRL && blk.payload == am_pattern(l))
                                hit = 1'b1;
                return hit;
        endfunction

        // Marker removed only if its lane was locked before it, replaced in place by an idle
        function automatic pcs_block_t reference_block(input pcs_block_t blk, input int lane,
                                                       input logic am_slot, output logic removed);
                logic good;
                removed = 1'b0;
                good    = (blk.sh == SH_CTRL) && (blk.payload == am_pattern(lane));
                if (am_slot)
                begin
                        case (ref_state[lane])
                        S_LOCK:
                                if (good)
                                        removed = 1'b1;
                                else
                                        ref_state[lane] = S_HUNT;       // Bad marker loses lock
                        S_ONE:
                                ref_state[lane] = good ? S_LOCK : S_HUNT;
                        default:
                                if (good)
                                        ref_state[lane] = S_ONE;
                        endcase
                end
                return removed ? PCS_IDLE : blk;
        endfunction

        function automatic logic [N_LANES-1:0] expected_lock();
                logic [N_LANES-1:0] lock;
                for (int l = 0; l < N_LANES; l++)
                        lock[l] = (ref_state[l] == S_LOCK);
                return lock;
        endfunction

        task automatic report_error(input string msg);
                $display("error: %0t: %s", $time, msg);
                $display("STATUS: FAIL");
                $fatal(1, "stopped at first error");
        endtask

        task automatic compare_block(input pcs_block_t got, input pcs_block_t exp);
                if (got !== exp)
                        report_error($sformatf("o_block got %b/%h, expected %b/%h",
                                               got.sh, got.payload, exp.sh, exp.payload));
        endtask

        task automatic compare_lock(input logic [N_LANES-1:0] got, input logic [N_LANES-1:0] exp);
                if (got !== exp)
                        report_error($sformatf("o_lane_locked got %b, expected %b", got, exp));
        endtask

        task automatic compare_count(input int got, input int exp, input string what);
                if (got != exp)
                        report_error($sformatf("%s got %0d, expected %0d", what, got, exp));
        endtask

        // One block per call, sometimes after a cycle with valid low
        task automatic send_block(input pcs_block_t blk, input int slot);
                expect_t e;
                logic    removed;
                if (lcg_next() % 8 == 0)
                begin
                        i_valid = 1'b0;
                        i_block = random_data();        // Must be ignored
                        @(negedge i_clock);
                end
                e.blk        = reference_block(blk, slot % N_LANES, slot < N_LANES, removed);
                e.lock       = expected_lock();
                e.lock_chk   = (slot >= N_LANES) && (slot < PERIOD - N_LANES);
                e.period_end = (slot == PERIOD - 1);
                if (blk == PCS_IDLE)
                        in_idles++;
                if (removed)
                        removed_cnt++;
                else if (is_marker(blk))
                        markers_passed++;
                e.idles_in = in_idles;
                e.removed  = removed_cnt;
                exp_q.push_back(e);
                i_valid = 1'b1;
                i_block = blk;
                in_valid_cnt++;
                @(negedge i_clock);
        endtask

        // Markers first, packets in the middle, idle run at the end
        task automatic send_period(input int period);
                pcs_block_t blk;
                int         pkt_left;
                int         idle_left;
                pkt_left  = 0;
                idle_left = N_LANES;
                for (int slot = 0; slot < PERIOD; slot++)
                begin
                        if (slot < N_LANES)
                        begin
                                blk.sh      = SH_CTRL;
                                blk.payload = am_pattern(slot);         // Lane equals slot here
                                if (period == CORRUPT_PERIOD && slot == CORRUPT_LANE)
                                        blk.payload = blk.payload ^ CORRUPT_MASK;
                        end
                        else if (slot >= PERIOD - N_LANES)
                                blk = PCS_IDLE;         // Control run ahead of next markers
                        else if (idle_left > 0)
                        begin
                                blk = PCS_IDLE;
                                idle_left--;
                                if (idle_left == 0)
                                        pkt_left = 1 + lcg_next() % 12;
                        end
                        else
                        begin
                                blk = random_data();
                                pkt_left--;
                                if (pkt_left == 0)
                                        idle_left = N_LANES + lcg_next() % 4;
                        end
                        send_block(blk, slot);
                end
        endtask

        always @(posedge i_clock)
                valid_hist <= {valid_hist[LATENCY-2:0], i_valid};

        // Outputs are stable at the falling edge
        always @(negedge i_clock)
        begin : compare_outputs
                expect_t e;
                if (i_rst_n === 1'b1)
                begin
                        if (o_valid !== valid_hist[LATENCY-1])
                                report_error("o_valid does not follow i_valid after the latency");
                        else if (o_valid === 1'b1)
                        begin
                                if (exp_q.size() == 0)
                                        report_error("output block without a matching input");
                                else
                                begin
                                        e = exp_q.pop_front();
                                        out_valid_cnt++;
                                        if (o_block == PCS_IDLE)
                                                out_idles++;
                                        if (is_marker(o_block))
                                                markers_seen++;
                                        compare_block(o_block, e.blk);
                                        if (e.lock_chk)
                                                compare_lock(o_lane_locked, e.lock);
                                        if (e.period_end)
                                                compare_count(out_idles - int'(e.idles_in),
                                                              int'(e.removed),
                                                              "idle surplus at period end");
                                end
                        end
                end
        end

        always @(posedge i_clock)
        begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= CYCLE_LIMIT)
                begin
                        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                        $display("STATUS: FAIL");
                        $fatal(1, "timeout");
                end
        end

        initial
        begin
                i_rst_n = 1'b0;
                i_valid = 1'b0;
                i_block = '0;
                repeat (RESET_CYCLES) @(posedge i_clock);
                @(negedge i_clock);
                i_rst_n = 1'b1;
                for (int p = 0; p < N_PERIODS; p++)
                        send_period(p);
                i_valid = 1'b0;
                i_block = '0;
                while (exp_q.size() != 0)
                        @(negedge i_clock);
                repeat (2 * LATENCY) @(negedge i_clock);        // No stray outputs
                compare_count(out_valid_cnt, in_valid_cnt, "o_valid pulses");
                compare_count(markers_seen, markers_passed, "markers on o_block");
                $display("STATUS: PASS");
                $finish;
        end

endmodule

// File: src/pcs_rx_backend.sv
`timescale 1ns/1ps

module pcs_rx_backend
        import pcs_pkg::*;
#(
        parameter int N_LANES         = 4,
        parameter int AM_BLOCK_PERIOD = 16
)
(
        input  logic               i_clock,
        input  logic               i_rst_n,
        input  logic               i_valid,
        input  pcs_block_t         i_block,
        output logic               o_valid,
        output pcs_block_t         o_block,
        output logic [N_LANES-1:0] o_lane_locked
);

        logic [N_LANES-1:0] lane_valid;                 // Distributor to checkers
        pcs_block_t         lane_block [N_LANES];
        logic [N_LANES-1:0] chk_valid;                  // Checkers to merger
        pcs_tagged_t        chk_tagged [N_LANES];
        logic               mrg_valid;
        pcs_tagged_t        mrg_tagged;
        logic               ctrl_state;

        lane_distributor #(
                .N_LANES (N_LANES)
        ) lane_distributor_inst (
                .i_clock      (i_clock),
                .i_rst_n      (i_rst_n),
                .i_valid      (i_valid),
                .i_block      (i_block),
                .o_lane_valid (lane_valid),
                .o_lane_block (lane_block)
        );

        // One marker checker per virtual lane
        for (genvar i = 0; i < N_LANES; i++)
        begin : g_lane
                lane_am_checker #(
                        .LANE            (i),
                        .AM_BLOCK_PERIOD (AM_BLOCK_PERIOD)
                ) lane_am_checker_inst (
                        .i_clock  (i_clock),
                        .i_rst_n  (i_rst_n),
                        .i_valid  (lane_valid[i]),
                        .i_block  (lane_block[i]),
                        .o_valid  (chk_valid[i]),
                        .o_tagged (chk_tagged[i]),
                        .o_locked (o_lane_locked[i])
                );
        end

        lane_merger #(
                .N_LANES (N_LANES)
        ) lane_merger_inst (
                .i_clock       (i_clock),
                .i_rst_n       (i_rst_n),
                .i_lane_valid  (chk_valid),
                .i_lane_tagged (chk_tagged),
                .o_valid       (mrg_valid),
                .o_tagged      (mrg_tagged)
        );

        clock_comp_rx #(
                .N_LANES         (N_LANES),
                .AM_BLOCK_PERIOD (AM_BLOCK_PERIOD)
        ) clock_comp_rx_inst (
                .i_clock      (i_clock),
                .i_rst_n      (i_rst_n),
                .i_valid      (mrg_valid),
                .i_tagged     (mrg_tagged),
                .i_ctrl_state (ctrl_state),
                .o_valid      (o_valid),
                .o_block      (o_block)
        );

        // Watches the compensated output
        rx_block_fsm rx_block_fsm_inst (
                .i_clock      (i_clock),
                .i_rst_n      (i_rst_n),
                .i_valid      (o_valid),
                .i_block      (o_block),
                .o_ctrl_state (ctrl_state)
        );

endmodule

// File: src/rx_block_fsm.sv
`timescale 1ns/1ps

module rx_block_fsm
        import pcs_pkg::*;
(
        input  logic       i_clock,
        input  logic       i_rst_n,
        input  logic       i_valid,
        input  pcs_block_t i_block,
        output logic       o_ctrl_state
);

        typedef enum logic [1:0] {RX_C, RX_D, RX_E} state_t;

        state_t state;

        assign o_ctrl_state = (state == RX_C);

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                        state <= RX_C;                  // Link starts between packets
                else if (i_valid)
                begin
                        case (i_block.sh)
                        SH_CTRL:
                                state <= RX_C;          // Also the way out of error
                        SH_DATA:
                                if (state != RX_E)
                                        state <= RX_D;
                        default:
                                state <= RX_E;          // Illegal header
                        endcase
                end
        end

endmodule

// File: clock_comp/clock_comp_rx.sv
`timescale 1ns/1ps

module clock_comp_rx
        import pcs_pkg::*;
#(
        parameter int N_LANES         = 4,
        parameter int AM_BLOCK_PERIOD = 16
)
(
        input  logic        i_clock,
        input  logic        i_rst_n,
        input  logic        i_valid,
        input  pcs_tagged_t i_tagged,
        input  logic        i_ctrl_state,           // Output stream is in a control run
        output logic        o_valid,
        output pcs_block_t  o_block
);

        localparam int PERIOD = N_LANES * AM_BLOCK_PERIOD;
        localparam int PER_W  = $clog2(PERIOD);
        localparam int CNT_W  = $clog2(N_LANES + 1) + 1;       // Room for carry-over

        logic [PER_W-1:0] period_cnt;
        logic [CNT_W-1:0] drop_cnt;                     // Markers dropped
        logic [CNT_W-1:0] idle_cnt;                     // Idles inserted
        logic [CNT_W-1:0] drop_nxt;
        logic [CNT_W-1:0] idle_nxt;
        logic             period_end;
        logic             am_drop;
        logic             fifo_write;
        logic             fifo_read;
        logic             fifo_empty;
        logic             rd_req;                       // Output slot owed one cycle after input
        logic             idle_insert;
        pcs_block_t       fifo_data;

        assign am_drop    = i_valid && i_tagged.am;
        assign fifo_write = i_valid && !i_tagged.am;    // Markers never enter the FIFO
        assign period_end = i_valid && (period_cnt == PER_W'(PERIOD - 1));

        // Idle only where the receive FSM expects control blocks
        assign idle_insert = rd_req && (drop_cnt > idle_cnt) && i_ctrl_state;
        assign fifo_read   = rd_req && !idle_insert;

        assign drop_nxt = drop_cnt + CNT_W'(am_drop);
        assign idle_nxt = idle_cnt + CNT_W'(idle_insert);

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        period_cnt <= '0;
                        drop_cnt   <= '0;
                        idle_cnt   <= '0;
                        rd_req     <= 1'b0;
                        o_valid    <= 1'b0;
                end
                else
                begin
                        rd_req  <= i_valid;
                        o_valid <= rd_req;
                        if (period_end)
                        begin
                                period_cnt <= '0;
                                drop_cnt   <= drop_nxt - idle_nxt;      // Carry unpaid markers
                                idle_cnt   <= '0;
                        end
                        else
                        begin
                                if (i_valid)
                                        period_cnt <= period_cnt + 1'b1;
                                drop_cnt <= drop_nxt;
                                idle_cnt <= idle_nxt;
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (rd_req)
                        o_block <= idle_insert ? PCS_IDLE : fifo_data;
        end

        sync_fifo #(
                .DEPTH              (32),
                .WR_PTR_AFTER_RESET (1)
        ) sync_fifo_inst (
                .i_clock  (i_clock),
                .i_rst_n  (i_rst_n),
                .i_write  (fifo_write),
                .i_read   (fifo_read),
                .i_data   (i_tagged.blk),
                .o_data   (fifo_data),
                .o_empty  (fifo_empty),
                .o_full   ()
        );

        // An owed slot that is not an idle needs a block in the FIFO
        a_no_underflow: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                (rd_req && !idle_insert) |-> !fifo_empty);

endmodule

// File: src/lane_merger.sv
`timescale 1ns/1ps

module lane_merger
        import pcs_pkg::*;
#(
        parameter int N_LANES = 4
)
(
        input  logic                 i_clock,
        input  logic                 i_rst_n,
        input  logic [N_LANES-1:0]   i_lane_valid,
        input  pcs_tagged_t          i_lane_tagged [N_LANES],
        output logic                 o_valid,
        output pcs_tagged_t          o_tagged
);

        localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

        logic [PTR_W-1:0] lane_ptr;                     // Same order as the distributor
        logic             lane_hit;

        assign lane_hit = i_lane_valid[lane_ptr];

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        lane_ptr <= '0;
                        o_valid  <= 1'b0;
                end
                else
                begin
                        o_valid <= lane_hit;
                        if (lane_hit)
                        begin
                                if (lane_ptr == PTR_W'(N_LANES - 1))
                                        lane_ptr <= '0;
                                else
                                        lane_ptr <= lane_ptr + 1'b1;
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (lane_hit)
                        o_tagged <= i_lane_tagged[lane_ptr];
        end

        // Lanes must arrive in strict round-robin order
        a_lane_order: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                (i_lane_valid != '0) |-> (i_lane_valid == (N_LANES'(1) << lane_ptr)));

endmodule

// File: lane_am/lane_am_checker.sv
`timescale 1ns/1ps

module lane_am_checker
        import pcs_pkg::*;
#(
        parameter int LANE            = 0,
        parameter int AM_BLOCK_PERIOD = 16
)
(
        input  logic        i_clock,
        input  logic        i_rst_n,
        input  logic        i_valid,
        input  pcs_block_t  i_block,
        output logic        o_valid,
        output pcs_tagged_t o_tagged,
        output logic        o_locked
);

        localparam int CNT_W = $clog2(AM_BLOCK_PERIOD);

        typedef enum logic [1:0] {ST_HUNT, ST_ONE, ST_LOCK} state_t;

        state_t           state;
        logic [CNT_W-1:0] blk_cnt;                      // Lane blocks since last marker
        logic             am_match;
        logic             am_slot;
        logic             am_tag;

        // Marker is a control block with this lane's payload
        assign am_match = (i_block.sh == SH_CTRL) && (i_block.payload == am_pattern(LANE));
        assign am_slot  = (blk_cnt == CNT_W'(AM_BLOCK_PERIOD - 1));    // Expected marker position
        assign am_tag   = (state == ST_LOCK) && am_slot && am_match;
        assign o_locked = (state == ST_LOCK);

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        state   <= ST_HUNT;
                        blk_cnt <= '0;
                        o_valid <= 1'b0;
                end
                else
                begin
                        o_valid <= i_valid;
                        if (i_valid)
                        begin
                                blk_cnt <= blk_cnt + 1'b1;
                                case (state)
                                ST_HUNT:
                                        if (am_match)
                                        begin
                                                state   <= ST_ONE;      // First marker found
                                                blk_cnt <= '0;
                                        end
                                ST_ONE:
                                        if (am_slot && am_match)
                                        begin
                                                state   <= ST_LOCK;     // Second one a period later
                                                blk_cnt <= '0;
                                        end
                                        else if (am_match)
                                                blk_cnt <= '0;          // Restart from newer marker
                                        else if (am_slot)
                                                state <= ST_HUNT;
                                default:
                                        if (am_slot)
                                        begin
                                                blk_cnt <= '0;
                                                if (!am_match)
                                                        state <= ST_HUNT;       // Lost marker
                                        end
                                endcase
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                        o_tagged <= '{blk: i_block, am: am_tag};        // Block is unchanged
        end

endmodule

// File: src/lane_distributor.sv
`timescale 1ns/1ps

module lane_distributor
        import pcs_pkg::*;
#(
        parameter int N_LANES = 4
)
(
        input  logic                 i_clock,
        input  logic                 i_rst_n,
        input  logic                 i_valid,
        input  pcs_block_t           i_block,
        output logic [N_LANES-1:0]   o_lane_valid,
        output pcs_block_t           o_lane_block [N_LANES]
);

        localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

        logic [PTR_W-1:0] lane_ptr;                     // Lane that takes the next block

        // Pointer and one-hot lane valids
        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        lane_ptr     <= '0;
                        o_lane_valid <= '0;
                end
                else
                begin
                        o_lane_valid <= '0;
                        if (i_valid)
                        begin
                                o_lane_valid[lane_ptr] <= 1'b1;
                                // Wrap after last lane
                                if (lane_ptr == PTR_W'(N_LANES - 1))
                                        lane_ptr <= '0;
                                else
                                        lane_ptr <= lane_ptr + 1'b1;
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                        o_lane_block[lane_ptr] <= i_block;      // Only the selected lane
        end

        a_one_lane: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                $onehot0(o_lane_valid));

endmodule

// File: clock_comp/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
        import pcs_pkg::*;
#(
        parameter int DEPTH              = 32,  // Power of two
        parameter int WR_PTR_AFTER_RESET = 1
)
(
        input  logic       i_clock,
        input  logic       i_rst_n,
        input  logic       i_write,
        input  logic       i_read,
        input  pcs_block_t i_data,
        output pcs_block_t o_data,
        output logic       o_empty,
        output logic       o_full
);

        localparam int AW = $clog2(DEPTH);

        pcs_block_t    mem [DEPTH];
        logic [AW-1:0] wr_ptr;
        logic [AW-1:0] rd_ptr;
        logic [AW-1:0] rd_addr;
        logic [AW-1:0] level;

        // Read side trails the write pointer by the reset offset
        assign rd_addr = rd_ptr + AW'(WR_PTR_AFTER_RESET);
        assign level   = wr_ptr - rd_addr;              // Entries held
        assign o_empty = (level == '0);
        assign o_full  = (level == AW'(DEPTH - 1));
        assign o_data  = mem[rd_addr];                  // Show-ahead

        always_ff @(posedge i_clock)
        begin
                if (!i_rst_n)
                begin
                        wr_ptr <= AW'(WR_PTR_AFTER_RESET);
                        rd_ptr <= '0;
                end
                else
                begin
                        if (i_write)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (i_read)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_write)
                        mem[wr_ptr] <= i_data;
        end

        a_no_overflow: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                i_write |-> !o_full);

        a_no_empty_read: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                i_read |-> !o_empty);

endmodule

// File: common/pcs_pkg.sv
package pcs_pkg;

        // One 64b/66b block
        typedef struct packed {
                logic [1:0]  sh;        // Sync header
                logic [63:0] payload;
        } pcs_block_t;

        // Block plus marker flag set by the lane checkers
        typedef struct packed {
                pcs_block_t blk;
                logic       am;         // Tagged as alignment marker
        } pcs_tagged_t;

        // Legal sync headers, 00 and 11 are illegal
        localparam logic [1:0] SH_DATA = 2'b01;
        localparam logic [1:0] SH_CTRL = 2'b10;

        // All-idle control block, type byte in bit-reversed order as on the line
        localparam pcs_block_t PCS_IDLE = '{
                sh:      SH_CTRL,
                payload: 64'he000_0000_0000_0000
        };

        // Common part of every lane marker
        localparam logic [63:0] AM_BASE = 64'hc168_2100_3e97_de00;

        // Marker payload of one lane
        function automatic logic [63:0] am_pattern(input int unsigned lane);
                logic [7:0] lane_byte;
                lane_byte = lane[7:0];                  // Lane number in low byte
                return {AM_BASE[63:8], lane_byte};
        endfunction

endpackage
